// File: align/ins_aligner.sv
/*
  Byte window aligner. Assumes a sequential stream from RESET_PC with no redirects.
  Issue only happens while room is high, so the lanes never stall.
  Offsets are 8 bits wide, enough for LANES up to 24.
*/
`timescale 1ns/100ps
`default_nettype none

module ins_aligner #(
	parameter int LANES = 4,
	parameter fetch_pkg::pc_t RESET_PC = 32'h0000_1000
) (
	input wire clk,
	input wire rst_n,
	input wire line_valid,
	output logic line_ready,
	input wire [fetch_pkg::LINE_BYTES*8-1:0] line_data,
	input wire room,
	lane_if.src lanes [LANES]
);

	localparam int OFF_W = 8;
	localparam int WIN_W = fetch_pkg::WIN_BYTES * 8;

	// Window bytes, byte 0 is the head of the stream
	logic [WIN_W-1:0] win;
	// Number of valid bytes in the window
	logic [OFF_W-1:0] fill;
	// Address of window byte 0
	fetch_pkg::pc_t head_pc;
	// Goes high on the first edge after reset and holds intake off until then
	logic run;

	logic [OFF_W-1:0] consumed;
	logic [OFF_W-1:0] fill_left;
	logic [OFF_W-1:0] fill_next;
	logic [WIN_W-1:0] win_shift;
	logic [WIN_W-1:0] keep_mask;
	logic [WIN_W-1:0] line_ext;
	logic [WIN_W-1:0] win_next;
	logic accept;

	// ====================
	// Boundary chain
	// ====================

	// Each stage starts where the previous instruction ends
	for (genvar i = 0; i < LANES; i++) begin : g_lane
		logic [OFF_W-1:0] off_start;
		logic [OFF_W-1:0] off_end;
		logic [OFF_W-1:0] cons_in;
		logic [OFF_W-1:0] cons_out;
		logic [WIN_W-1:0] view;
		logic [qupls_isa_pkg::LEN_W-1:0] len;
		logic issue;

		if (i == 0) begin : g_head
			assign off_start = '0;
			assign cons_in = '0;
		end else begin : g_link
			assign off_start = g_lane[i-1].off_end;
			assign cons_in = g_lane[i-1].cons_out;
		end

		// Bring this lane's first byte down to bit 0
		assign view = win >> {off_start, 3'b000};

		qupls_ins_length u_ins_length (
			.op(view[6:0]),
			.len(len)
		);

		assign off_end = off_start + OFF_W'(len);

		// Ends are increasing, so the issued lanes always form a prefix
		assign issue = room && (off_end <= fill);
		assign cons_out = issue ? off_end : cons_in;

		assign lanes[i].valid = issue;
		assign lanes[i].pc = head_pc + fetch_pkg::pc_t'(off_start);
		assign lanes[i].bytes = view[qupls_isa_pkg::MAX_INS_BYTES*8-1:0];
		assign lanes[i].len = len;
	end

	// Bytes leaving the window this cycle
	assign consumed = g_lane[LANES-1].cons_out;

	// ====================
	// Window update
	// ====================

	always_comb begin
		fill_left = fill - consumed;
		// Space for one more line once this cycle's issue is removed
		line_ready = run && (fill_left <= OFF_W'(fetch_pkg::LINE_BYTES));
		accept = line_valid && line_ready;
		win_shift = win >> {consumed, 3'b000};
		// Stale bytes above the fill must not mix with the new line
		keep_mask = ~({WIN_W{1'b1}} << {fill_left, 3'b000});
		line_ext = WIN_W'(line_data) << {fill_left, 3'b000};
		win_next = win_shift & keep_mask;
		fill_next = fill_left;
		if (accept) begin
			win_next = win_next | line_ext;
			fill_next = fill_left + OFF_W'(fetch_pkg::LINE_BYTES);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run <= 1'b0;
			fill <= '0;
			head_pc <= RESET_PC;
		end else begin
			run <= 1'b1;
			fill <= fill_next;
			head_pc <= head_pc + fetch_pkg::pc_t'(consumed);
		end
	end

	// Bytes beyond fill are ignored, so the window itself needs no clear
	always_ff @(posedge clk) begin
		win <= win_next;
	end

endmodule

`default_nettype wire

// File: align/qupls_ins_length.sv
/*
  Opcode to length lookup, purely combinational.
  Unknown opcodes decode as 5 bytes so the chain always moves forward.
*/
`timescale 1ns/100ps
`default_nettype none

module qupls_ins_length (
	input wire qupls_isa_pkg::opcode_t op,
	output logic [qupls_isa_pkg::LEN_W-1:0] len
);

	always_comb begin
		case (op)
			// Only the 64-bit prefixes carry a full 8-byte constant
			qupls_isa_pkg::OP_PFXA64,
			qupls_isa_pkg::OP_PFXB64,
			qupls_isa_pkg::OP_PFXC64:
				len = 5'd10;
			// Branches, 32-bit prefixes and all other opcodes use the standard format
			// An X opcode from an empty window also lands here
			default:
				len = 5'd5;
		endcase
	end

endmodule

`default_nettype wire

// File: common/fetch_pkg.sv
/*
  Fetch-side types. Addresses are byte addresses.
  A fetch line is 16 bytes and the aligner window holds two of them.
*/
`default_nettype none

package fetch_pkg;

	// Bytes per incoming fetch line
	localparam int LINE_BYTES = 16;
	// Bytes held by the aligner window
	localparam int WIN_BYTES = 32;

	// Byte address of an instruction
	typedef logic [31:0] pc_t;

	// One predecoded instruction as it leaves the front end
	typedef struct packed {
		pc_t pc;
		qupls_isa_pkg::opcode_t opcode;
		logic [qupls_isa_pkg::REG_W-1:0] rd;
		logic [qupls_isa_pkg::REG_W-1:0] rs1;
		// Sign-extended short immediate or full prefix constant
		logic [qupls_isa_pkg::PFX_IMM_W-1:0] imm;
		logic [qupls_isa_pkg::LEN_W-1:0] len;
		logic is_branch;
		logic is_prefix;
	} predec_t;

endpackage

`default_nettype wire

// File: common/lane_if.sv
/*
  One aligned instruction on its way from the aligner to a predecode lane.
  There is no ready, space is granted by the queue before issue.
*/
`timescale 1ns/100ps
`default_nettype none

interface lane_if;

	// Instruction present in this lane for this cycle
	logic valid;
	// Address of the first byte
	fetch_pkg::pc_t pc;
	// Raw bytes, byte 0 in the low bits, unused tail bytes are don't care
	logic [qupls_isa_pkg::MAX_INS_BYTES*8-1:0] bytes;
	// Decoded length in bytes
	logic [qupls_isa_pkg::LEN_W-1:0] len;

	// Aligner side
	modport src (
		output valid,
		output pc,
		output bytes,
		output len
	);

	// Lane side
	modport dst (
		input valid,
		input pc,
		input bytes,
		input len
	);

endinterface

`default_nettype wire

// File: common/qupls_isa_pkg.sv
/*
  Opcode encodings and field widths of the variable-length ISA.
  Only the 32-bit and 64-bit prefixes exist here. 128-bit prefixes are not decoded.
*/
`default_nettype none

package qupls_isa_pkg;

	// ====================
	// Field widths
	// ====================

	// Opcode sits in the low seven bits of the first instruction byte
	typedef logic [6:0] opcode_t;

	// Register specifier width for rd and rs1
	localparam int REG_W = 6;
	// Immediate carried by a plain 5-byte instruction
	localparam int IMM_W = 21;
	// Immediate carried by a 64-bit prefix, bytes 2 to 9
	localparam int PFX_IMM_W = 64;
	// Longest instruction the front end handles
	localparam int MAX_INS_BYTES = 10;
	// Width of a length value in bytes
	localparam int LEN_W = 5;

	// ====================
	// Opcodes
	// ====================

	// Subroutine calls
	localparam opcode_t OP_BSR = 7'h20;
	localparam opcode_t OP_JSR = 7'h21;

	// Integer and float conditional branches
	localparam opcode_t OP_BccU = 7'h26;
	localparam opcode_t OP_Bcc = 7'h27;
	localparam opcode_t OP_FBccH = 7'h28;
	localparam opcode_t OP_FBccS = 7'h29;
	localparam opcode_t OP_FBccD = 7'h2A;
	localparam opcode_t OP_FBccQ = 7'h2B;

	// System and float arithmetic
	localparam opcode_t OP_CSR = 7'h07;
	localparam opcode_t OP_FLT3 = 7'h0C;

	// Constant prefixes, the 32-bit ones are still 5 bytes long
	localparam opcode_t OP_PFXA32 = 7'h30;
	localparam opcode_t OP_PFXB32 = 7'h31;
	localparam opcode_t OP_PFXC32 = 7'h32;
	localparam opcode_t OP_PFXA64 = 7'h34;
	localparam opcode_t OP_PFXB64 = 7'h35;
	localparam opcode_t OP_PFXC64 = 7'h36;

	// Return, no-op and context save
	localparam opcode_t OP_RTD = 7'h3A;
	localparam opcode_t OP_LSCTX = 7'h3E;
	localparam opcode_t OP_NOP = 7'h3F;

endpackage

`default_nettype wire

// File: list.f
common/qupls_isa_pkg.sv
common/fetch_pkg.sv
common/lane_if.sv
align/qupls_ins_length.sv
align/ins_aligner.sv
src/predecode_lane.sv
src/dispatch_queue.sv
src/fetch_align_top.sv
tests/tb_fetch_align.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# The exit status of the simulation is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module tb_fetch_align \
	--Mdir build \
	-o tb_fetch_align \
	-f list.f

./build/tb_fetch_align

// File: src/dispatch_queue.sv
/*
  In-order queue, up to LANES writes and one read per cycle.
  QUEUE_DEPTH must be a power of two and at least 2*LANES.
  Valid lanes are expected to form a prefix of the lane order.
*/
`timescale 1ns/100ps
`default_nettype none

module dispatch_queue #(
	parameter int LANES = 4,
	parameter int QUEUE_DEPTH = 16
) (
	input wire clk,
	input wire rst_n,
	input wire [LANES-1:0] pd_valid,
	input wire fetch_pkg::predec_t pd [LANES],
	output logic room,
	output logic out_valid,
	input wire out_ready,
	output fetch_pkg::predec_t out_pd
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);

	fetch_pkg::predec_t mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] wptr;
	logic [PTR_W-1:0] rptr;
	logic [PTR_W:0] count;

	logic [PTR_W-1:0] widx [LANES];
	logic [PTR_W:0] n_wr;
	logic [PTR_W:0] count_next;
	logic rd;

	// ====================
	// Pointers and count
	// ====================

	always_comb begin
		n_wr = '0;
		for (int i = 0; i < LANES; i++) begin
			// Lane i lands i slots past the write pointer
			widx[i] = wptr + PTR_W'(i);
			n_wr = n_wr + (PTR_W+1)'(pd_valid[i]);
		end
	end

	// Oldest entry is shown whenever the queue is not empty
	assign out_valid = (count != '0);
	assign out_pd = mem[rptr];
	assign rd = out_valid && out_ready;

	assign count_next = count + n_wr - (PTR_W+1)'(rd);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wptr <= '0;
			rptr <= '0;
			count <= '0;
			room <= 1'b0;
		end else begin
			wptr <= wptr + n_wr[PTR_W-1:0];
			if (rd) begin
				rptr <= rptr + 1'b1;
			end
			count <= count_next;
			// Keeps space for a bundle in the lanes and one more behind it
			room <= (QUEUE_DEPTH - int'(count_next)) >= 2 * LANES;
		end
	end

	// ====================
	// Storage
	// ====================

	always_ff @(posedge clk) begin
		for (int i = 0; i < LANES; i++) begin
			if (pd_valid[i]) begin
				mem[widx[i]] <= pd[i];
			end
		end
	end

endmodule

`default_nettype wire

// File: src/fetch_align_top.sv
/*
  Fetch-align and predecode front end. Sequential stream only, no flush.
  Both ports are valid/ready, a transfer needs both high on a rising edge.
*/
`timescale 1ns/100ps
`default_nettype none

module fetch_align_top #(
	parameter int LANES = 4,
	parameter int QUEUE_DEPTH = 16,
	parameter fetch_pkg::pc_t RESET_PC = 32'h0000_1000
) (
	input wire clk,
	input wire rst_n,
	input wire line_valid,
	output logic line_ready,
	input wire [fetch_pkg::LINE_BYTES*8-1:0] line_data,
	output logic out_valid,
	input wire out_ready,
	output fetch_pkg::pc_t out_pc,
	output qupls_isa_pkg::opcode_t out_opcode,
	output logic [qupls_isa_pkg::REG_W-1:0] out_rd,
	output logic [qupls_isa_pkg::REG_W-1:0] out_rs1,
	output logic [qupls_isa_pkg::PFX_IMM_W-1:0] out_imm,
	output logic [qupls_isa_pkg::LEN_W-1:0] out_len,
	output logic out_is_branch,
	output logic out_is_prefix
);

	lane_if lane_bus [LANES] ();

	logic room;
	logic [LANES-1:0] lane_valid;
	fetch_pkg::predec_t lane_pd [LANES];
	fetch_pkg::predec_t out_pd;

	ins_aligner #(
		.LANES(LANES),
		.RESET_PC(RESET_PC)
	) u_aligner (
		.clk(clk),
		.rst_n(rst_n),
		.line_valid(line_valid),
		.line_ready(line_ready),
		.line_data(line_data),
		.room(room),
		.lanes(lane_bus)
	);

	// One predecoder per issue slot
	for (genvar i = 0; i < LANES; i++) begin : g_lane
		predecode_lane u_lane (
			.clk(clk),
			.rst_n(rst_n),
			.ins(lane_bus[i]),
			.pd_valid(lane_valid[i]),
			.pd(lane_pd[i])
		);
	end

	dispatch_queue #(
		.LANES(LANES),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_queue (
		.clk(clk),
		.rst_n(rst_n),
		.pd_valid(lane_valid),
		.pd(lane_pd),
		.room(room),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_pd(out_pd)
	);

	// Output struct split into the plain top level ports
	assign out_pc = out_pd.pc;
	assign out_opcode = out_pd.opcode;
	assign out_rd = out_pd.rd;
	assign out_rs1 = out_pd.rs1;
	assign out_imm = out_pd.imm;
	assign out_len = out_pd.len;
	assign out_is_branch = out_pd.is_branch;
	assign out_is_prefix = out_pd.is_prefix;

endmodule

`default_nettype wire

// File: src/predecode_lane.sv
/*
  One predecode lane, one cycle from ins.valid to pd_valid.
  pd only updates on a valid instruction and holds otherwise.
*/
`timescale 1ns/100ps
`default_nettype none

module predecode_lane (
	input wire clk,
	input wire rst_n,
	lane_if.dst ins,
	output logic pd_valid,
	output fetch_pkg::predec_t pd
);

	localparam int IMM_SIGN = 19 + qupls_isa_pkg::IMM_W - 1;

	qupls_isa_pkg::opcode_t op;
	logic [qupls_isa_pkg::PFX_IMM_W-1:0] imm;
	logic is_branch;
	logic is_prefix;

	always_comb begin
		op = ins.bytes[6:0];

		// A 10-byte prefix carries its constant in bytes 2 to 9
		if (ins.len == qupls_isa_pkg::LEN_W'(qupls_isa_pkg::MAX_INS_BYTES)) begin
			imm = ins.bytes[16 +: qupls_isa_pkg::PFX_IMM_W];
		end else begin
			imm = {{(qupls_isa_pkg::PFX_IMM_W - qupls_isa_pkg::IMM_W){ins.bytes[IMM_SIGN]}},
				ins.bytes[19 +: qupls_isa_pkg::IMM_W]};
		end

		// Anything that can change the flow of control
		case (op)
			qupls_isa_pkg::OP_BSR, qupls_isa_pkg::OP_JSR,
			qupls_isa_pkg::OP_BccU, qupls_isa_pkg::OP_Bcc,
			qupls_isa_pkg::OP_FBccH, qupls_isa_pkg::OP_FBccS,
			qupls_isa_pkg::OP_FBccD, qupls_isa_pkg::OP_FBccQ,
			qupls_isa_pkg::OP_RTD:
				is_branch = 1'b1;
			default:
				is_branch = 1'b0;
		endcase

		case (op)
			qupls_isa_pkg::OP_PFXA32, qupls_isa_pkg::OP_PFXB32,
			qupls_isa_pkg::OP_PFXC32, qupls_isa_pkg::OP_PFXA64,
			qupls_isa_pkg::OP_PFXB64, qupls_isa_pkg::OP_PFXC64:
				is_prefix = 1'b1;
			default:
				is_prefix = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pd_valid <= 1'b0;
		end else begin
			pd_valid <= ins.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (ins.valid) begin
			pd.pc <= ins.pc;
			pd.opcode <= op;
			pd.rd <= ins.bytes[7 +: qupls_isa_pkg::REG_W];
			pd.rs1 <= ins.bytes[13 +: qupls_isa_pkg::REG_W];
			pd.imm <= imm;
			pd.len <= ins.len;
			pd.is_branch <= is_branch;
			pd.is_prefix <= is_prefix;
		end
	end

endmodule

`default_nettype wire

// File: tests/tb_fetch_align.sv
/*
  Testbench for fetch_align_top with 4 lanes and a 16-entry queue.
  The stream is one sequential run from RESET_PC, padded with 5-byte
  instructions to whole fetch lines so no partial instruction is left over.
*/
`timescale 1ns/100ps
`default_nettype none

module tb_fetch_align;

	localparam int LANES = 4;
	localparam int QUEUE_DEPTH = 16;
	localparam fetch_pkg::pc_t RESET_PC = 32'h0000_1000;
	// First part holds 5-byte instructions only, the second mixes in 64-bit prefixes
	localparam int PLAIN_COUNT = 40;
	localparam int MIXED_COUNT = 160;
	// Sixteen 5-byte opcodes first, then the three 10-byte prefixes
	localparam qupls_isa_pkg::opcode_t OP_LIST [19] = '{
		qupls_isa_pkg::OP_BSR, qupls_isa_pkg::OP_JSR, qupls_isa_pkg::OP_BccU,
		qupls_isa_pkg::OP_Bcc, qupls_isa_pkg::OP_FBccH, qupls_isa_pkg::OP_FBccS,
		qupls_isa_pkg::OP_FBccD, qupls_isa_pkg::OP_FBccQ, qupls_isa_pkg::OP_CSR,
		qupls_isa_pkg::OP_FLT3, qupls_isa_pkg::OP_PFXA32, qupls_isa_pkg::OP_PFXB32,
		qupls_isa_pkg::OP_PFXC32, qupls_isa_pkg::OP_RTD, qupls_isa_pkg::OP_NOP,
		qupls_isa_pkg::OP_LSCTX, qupls_isa_pkg::OP_PFXA64, qupls_isa_pkg::OP_PFXB64,
		qupls_isa_pkg::OP_PFXC64
	};

	logic clk;
	logic rst_n;
	logic line_valid;
	logic line_ready;
	logic [fetch_pkg::LINE_BYTES*8-1:0] line_data;
	logic out_valid;
	logic out_ready;
	fetch_pkg::pc_t out_pc;
	qupls_isa_pkg::opcode_t out_opcode;
	logic [qupls_isa_pkg::REG_W-1:0] out_rd;
	logic [qupls_isa_pkg::REG_W-1:0] out_rs1;
	logic [qupls_isa_pkg::PFX_IMM_W-1:0] out_imm;
	logic [qupls_isa_pkg::LEN_W-1:0] out_len;
	logic out_is_branch;
	logic out_is_prefix;

	logic [31:0] lfsr_state;
	logic [7:0] stream [$];
	fetch_pkg::predec_t exp_q [$];
	fetch_pkg::predec_t got_pd;
	logic stream_built;
	int n_exp;
	int n_out;
	int n_wide;

	fetch_align_top #(
		.LANES(LANES),
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.RESET_PC(RESET_PC)
	) dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.line_valid(line_valid),
		.line_ready(line_ready),
		.line_data(line_data),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_pc(out_pc),
		.out_opcode(out_opcode),
		.out_rd(out_rd),
		.out_rs1(out_rs1),
		.out_imm(out_imm),
		.out_len(out_len),
		.out_is_branch(out_is_branch),
		.out_is_prefix(out_is_prefix)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ====================
	// Random source
	// ====================

	// Taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit, newest bit ends up in bit 0
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	// ====================
	// Stream and reference
	// ====================

	function automatic logic is_wide(input qupls_isa_pkg::opcode_t op);
		return op == qupls_isa_pkg::OP_PFXA64 || op == qupls_isa_pkg::OP_PFXB64 ||
			op == qupls_isa_pkg::OP_PFXC64;
	endfunction

	// Opcode byte keeps a random top bit, all other bytes are random
	task automatic append_instruction(input qupls_isa_pkg::opcode_t op);
		logic [31:0] r;
		r = take_bits(1);
		stream.push_back({r[0], op});
		for (int k = 1; k < (is_wide(op) ? 10 : 5); k++) begin
			r = take_bits(8);
			stream.push_back(r[7:0]);
		end
	endtask

	task automatic build_stream();
		logic [31:0] r;
		for (int i = 0; i < PLAIN_COUNT; i++) begin
			r = take_bits(8);
			append_instruction(OP_LIST[r[3:0]]);
		end
		for (int i = 0; i < MIXED_COUNT; i++) begin
			r = take_bits(8);
			append_instruction(OP_LIST[int'(r[7:0]) % 19]);
		end
		// Five is odd, so this lands on a line boundary within 16 steps
		while (stream.size() % fetch_pkg::LINE_BYTES != 0) begin
			r = take_bits(8);
			append_instruction(OP_LIST[r[3:0]]);
		end
	endtask

	// Expected predecode of the instruction that starts at stream byte idx
	function automatic fetch_pkg::predec_t ref_predecode(input int idx);
		fetch_pkg::predec_t e;
		logic [79:0] ins;
		ins = '0;
		for (int k = 0; k < 10; k++) begin
			if (idx + k < stream.size()) begin
				ins[8*k +: 8] = stream[idx + k];
			end
		end
		e.pc = RESET_PC + fetch_pkg::pc_t'(idx);
		e.opcode = ins[6:0];
		e.rd = ins[12:7];
		e.rs1 = ins[18:13];
		e.len = is_wide(e.opcode) ? 5'd10 : 5'd5;
		// Prefix constant is little-endian in bytes 2 to 9
		e.imm = is_wide(e.opcode) ? ins[79:16] : {{43{ins[39]}}, ins[39:19]};
		case (e.opcode)
			qupls_isa_pkg::OP_BSR, qupls_isa_pkg::OP_JSR, qupls_isa_pkg::OP_BccU,
			qupls_isa_pkg::OP_Bcc, qupls_isa_pkg::OP_FBccH, qupls_isa_pkg::OP_FBccS,
			qupls_isa_pkg::OP_FBccD, qupls_isa_pkg::OP_FBccQ, qupls_isa_pkg::OP_RTD:
				e.is_branch = 1'b1;
			default:
				e.is_branch = 1'b0;
		endcase
		case (e.opcode)
			qupls_isa_pkg::OP_PFXA32, qupls_isa_pkg::OP_PFXB32, qupls_isa_pkg::OP_PFXC32,
			qupls_isa_pkg::OP_PFXA64, qupls_isa_pkg::OP_PFXB64, qupls_isa_pkg::OP_PFXC64:
				e.is_prefix = 1'b1;
			default:
				e.is_prefix = 1'b0;
		endcase
		return e;
	endfunction

	task automatic build_expected();
		fetch_pkg::predec_t e;
		int idx;
		idx = 0;
		while (idx < stream.size()) begin
			e = ref_predecode(idx);
			exp_q.push_back(e);
			if (e.len == 5'd10) n_wide++;
			idx += int'(e.len);
		end
		n_exp = exp_q.size();
	endtask

	function automatic logic [fetch_pkg::LINE_BYTES*8-1:0] line_bits(input int li);
		logic [fetch_pkg::LINE_BYTES*8-1:0] v;
		for (int k = 0; k < fetch_pkg::LINE_BYTES; k++) begin
			v[8*k +: 8] = stream[fetch_pkg::LINE_BYTES*li + k];
		end
		return v;
	endfunction

	// ====================
	// Checks
	// ====================

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			stop_run("Control output has the wrong level");
		end
	endtask

	task automatic check_predec(input fetch_pkg::predec_t got,
		input fetch_pkg::predec_t exp, input int index);
		if (got !== exp) begin
			$display("Mismatch at output %0d", index);
			if (got.pc !== exp.pc)
				$display("CHECK FAILED out_pc got %h expected %h", got.pc, exp.pc);
			if (got.opcode !== exp.opcode)
				$display("CHECK FAILED out_opcode got %h expected %h", got.opcode, exp.opcode);
			if (got.rd !== exp.rd)
				$display("CHECK FAILED out_rd got %h expected %h", got.rd, exp.rd);
			if (got.rs1 !== exp.rs1)
				$display("CHECK FAILED out_rs1 got %h expected %h", got.rs1, exp.rs1);
			if (got.imm !== exp.imm)
				$display("CHECK FAILED out_imm got %h expected %h", got.imm, exp.imm);
			if (got.len !== exp.len)
				$display("CHECK FAILED out_len got %h expected %h", got.len, exp.len);
			if (got.is_branch !== exp.is_branch)
				$display("CHECK FAILED out_is_branch got %h expected %h",
					got.is_branch, exp.is_branch);
			if (got.is_prefix !== exp.is_prefix)
				$display("CHECK FAILED out_is_prefix got %h expected %h",
					got.is_prefix, exp.is_prefix);
			stop_run("Predecoded instruction differs from the reference");
		end
	endtask

	task automatic check_count(input int got, input int exp);
		if (got != exp) begin
			$display("CHECK FAILED output count got %h expected %h", got, exp);
			stop_run("Number of outputs differs from the reference");
		end
	endtask

	// Both outputs stay low through reset and the first cycle after it
	initial begin
		repeat (10) begin
			@(posedge clk);
			@(negedge clk);
			check_flag("out_valid", out_valid, 1'b0);
			check_flag("line_ready", line_ready, 1'b0);
		end
	end

	// A transfer happens on the next rising edge when both are high here
	always @(negedge clk) begin
		if (rst_n && out_valid && out_ready) begin
			if (exp_q.size() == 0) begin
				stop_run("Output appeared after the whole stream was already seen");
			end else begin
				got_pd.pc = out_pc;
				got_pd.opcode = out_opcode;
				got_pd.rd = out_rd;
				got_pd.rs1 = out_rs1;
				got_pd.imm = out_imm;
				got_pd.len = out_len;
				got_pd.is_branch = out_is_branch;
				got_pd.is_prefix = out_is_prefix;
				check_predec(got_pd, exp_q.pop_front(), n_out);
				n_out++;
			end
		end
	end

	// Budget of 20 cycles for every stream byte
	initial begin
		wait (stream_built);
		@(posedge rst_n);
		repeat (20 * stream.size()) @(posedge clk);
		stop_run("Timeout, the output stream did not finish in time");
	end

	// ====================
	// Main sequence
	// ====================

	initial begin
		int line_idx;
		int n_lines;
		int quiet;
		logic take_line;
		logic [31:0] r;
		rst_n <= 1'b0;
		line_valid <= 1'b0;
		line_data <= '0;
		out_ready <= 1'b0;
		stream_built = 1'b0;
		n_out = 0;
		n_wide = 0;
		lfsr_state = 32'h9dea;
		build_stream();
		build_expected();
		n_lines = stream.size() / fetch_pkg::LINE_BYTES;
		stream_built = 1'b1;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		line_idx = 0;
		while (line_idx < n_lines) begin
			@(negedge clk);
			take_line = line_valid && line_ready;
			@(posedge clk);
			if (take_line) line_idx++;
			// A line that is offered stays put until it is taken
			if (!line_valid || take_line) begin
				r = take_bits(2);
				if (line_idx < n_lines && r[1:0] != 2'b00) begin
					line_valid <= 1'b1;
					line_data <= line_bits(line_idx);
				end else begin
					line_valid <= 1'b0;
				end
			end
			r = take_bits(1);
			out_ready <= r[0];
		end
		// All lines are in, drain until the output stays idle for a while
		out_ready <= 1'b1;
		quiet = 0;
		while (quiet < 10) begin
			@(negedge clk);
			if (out_valid) begin
				quiet = 0;
			end else begin
				quiet++;
			end
		end
		check_count(n_out, n_exp);
		$display("Checked %0d instructions, %0d of them 10-byte prefixes", n_out, n_wide);
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire
